// File: pat_alu.sv
`timescale 1ns/100ps

module pat_alu (
	input  pat_pkg::alu_op_e i_op,
	input  pat_pkg::data_t   i_a,
	input  pat_pkg::data_t   i_b,
	output pat_pkg::data_t   o_y
);
	import pat_pkg::*;

	logic                      do_sub;
	data_t                     b_add;   // b or ~b into the adder
	data_t                     sum;     // add/sub result, mod 256
	logic [2:0]                amt;     // shift distance 1..4
	logic signed [d_width-1:0] a_s;
	data_t                     shlz_y, shlo_y, shrz_y, asr_y;

	// ====================
	// add / subtract
	// ====================
	// one adder for both, subtract as a + ~b + 1
	assign do_sub = (i_op == alu_sub);
	assign b_add  = do_sub ? ~i_b : i_b;
	assign sum    = i_a + b_add + {{(d_width-1){1'b0}}, do_sub};

	// ====================
	// shifter
	// ====================
	assign amt    = {1'b0, i_b[1:0]} + 3'd1; // only b[1:0] matters
	assign a_s    = i_a;
	assign shlz_y = i_a << amt;
	assign shlo_y = (i_a << amt) | ~({d_width{1'b1}} << amt); // ones into the low end
	assign shrz_y = i_a >> amt;
	assign asr_y  = a_s >>> amt; // sign bit copied down

	// result select
	always_comb
	begin
		case (i_op)
			alu_or:    o_y = i_a | i_b;
			alu_and:   o_y = i_a & i_b;
			alu_add:   o_y = sum;
			alu_sub:   o_y = sum;
			alu_not_a: o_y = ~i_a;
			alu_shlz:  o_y = shlz_y;
			alu_shlo:  o_y = shlo_y;
			alu_shrz:  o_y = shrz_y;
			alu_asr:   o_y = asr_y;
			default:   o_y = i_b; // pass_b
		endcase
	end

endmodule

// File: pat_decoder.sv
`timescale 1ns/100ps

module pat_decoder (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [pat_pkg::i_width-1:0]  i_instruction,
	input  pat_pkg::data_t               i_in_0,
	input  pat_pkg::data_t               i_in_1,
	input  pat_pkg::data_t               i_in_2,
	output pat_pkg::reg_adr_t            o_rd_adr_a,
	output pat_pkg::reg_adr_t            o_rd_adr_b,
	input  pat_pkg::data_t               i_rd_data_a,
	input  pat_pkg::data_t               i_rd_data_b,
	pat_stage_if.decode                  stage
);
	import pat_pkg::*;

	logic [op_width-1:0]   op8, op3, op0;
	logic [cond_width-1:0] cond;
	reg_adr_t              rn;
	data_t                 imm;
	logic                  is_i8, is_i3;
	alu_op_e               alu_op;
	logic                  wr_reg, do_out, do_test, do_branch;
	logic                  use_reg_b, use_in;
	data_t                 ins [n_inputs];
	data_t                 in_value, op_a, reg_b, op_b;
	logic                  drop; // discard the word now on i_instruction

	// ====================
	// field split
	// ====================
	assign rn   = i_instruction[rn_lsb +: d_adr_width];
	assign cond = i_instruction[cond_lsb +: cond_width];
	assign op8  = i_instruction[op8_lsb +: op_width];
	assign op3  = i_instruction[op3_lsb +: op_width];
	assign op0  = i_instruction[op0_lsb +: op_width];
	assign imm  = i_instruction[imm_lsb +: d_width];

	assign is_i8 = (op8 != prefix_code);
	assign is_i3 = !is_i8 && (op3 != prefix_code); // else i0 space

	always_comb
	begin
		alu_op    = alu_pass_b; // ldi and in pass b straight through
		wr_reg    = 1'b1;
		do_out    = 1'b0;
		do_test   = 1'b0;
		do_branch = 1'b0;
		if (is_i8)
		begin
			case (op8)
				op8_ori, op8_orr:   alu_op = alu_or;
				op8_andi, op8_andr: alu_op = alu_and;
				op8_addi, op8_addr: alu_op = alu_add;
				op8_subi, op8_subr: alu_op = alu_sub;
				op8_ldi: ;
				op8_bf:
				begin
					wr_reg    = 1'b0;
					do_branch = 1'b1;
				end
				default: wr_reg = 1'b0; // unknown, behaves as nop
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				op3_shlz: alu_op = alu_shlz;
				op3_shlo: alu_op = alu_shlo;
				op3_shrz: alu_op = alu_shrz;
				op3_asr:  alu_op = alu_asr;
				op3_in: ;
				op3_out:
				begin
					wr_reg = 1'b0;
					do_out = 1'b1; // value is operand a
				end
				default: wr_reg = 1'b0;
			endcase
		end
		else
		begin
			case (op0)
				op0_not: alu_op = alu_not_a;
				op0_test:
				begin
					wr_reg  = 1'b0;
					do_test = 1'b1;
				end
				default: wr_reg = 1'b0; // nop and unknown
			endcase
		end
	end

	// ====================
	// operands
	// ====================
	assign use_reg_b = is_i8 && (op8 inside {op8_orr, op8_andr, op8_addr, op8_subr});
	assign use_in    = is_i3 && (op3 == op3_in);

	assign o_rd_adr_a = rn;
	assign o_rd_adr_b = imm[d_adr_width-1:0];

	assign ins = '{i_in_0, i_in_1, i_in_2};

	// one-hot port code
	always_comb
	begin
		case (imm[2:0])
			3'b010:  in_value = ins[1];
			3'b100:  in_value = ins[2];
			default: in_value = ins[0]; // 001 and any invalid code
		endcase
	end

	// bypass the value execute writes at this same edge
	assign op_a  = (stage.fwd_en && stage.fwd_dest == rn) ? stage.fwd_data : i_rd_data_a;
	assign reg_b = (stage.fwd_en && stage.fwd_dest == o_rd_adr_b) ?
		stage.fwd_data : i_rd_data_b;
	assign op_b  = use_in ? in_value : (use_reg_b ? reg_b : imm); // imm also carries shift amt

	// ====================
	// stage register
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stage.valid <= 1'b0;
			drop        <= 1'b1; // word fetched during reset is stale
		end
		else if (stage.flush)
		begin
			stage.valid <= 1'b0; // kill the first shadow slot
			drop        <= 1'b1; // and the second one next cycle
		end
		else
		begin
			stage.valid <= !drop;
			drop        <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		stage.alu_op    <= alu_op;
		stage.operand_a <= op_a;
		stage.operand_b <= op_b;
		stage.dest      <= rn;
		stage.cond      <= cond;
		stage.wr_reg    <= wr_reg;
		stage.do_out    <= do_out;
		stage.do_test   <= do_test;
		stage.do_branch <= do_branch;
		stage.offset    <= imm;
	end

endmodule

// File: pat_execute.sv
`timescale 1ns/100ps

module pat_execute (
	input  logic              clk,
	input  logic              reset,
	pat_stage_if.execute      stage,
	output logic              o_wr_en,
	output pat_pkg::reg_adr_t o_wr_adr,
	output pat_pkg::data_t    o_wr_data,
	output logic              o_branch,
	output pat_pkg::data_t    o_offset,
	output pat_pkg::data_t    o_out_value,
	output logic              o_out_valid
);
	import pat_pkg::*;

	logic  z_flag;  // set only by test
	logic  n_flag;
	logic  cond_ok;
	logic  commit;  // valid and condition met
	data_t alu_y;

	pat_alu u_alu (
		.i_op (stage.alu_op),
		.i_a  (stage.operand_a),
		.i_b  (stage.operand_b),
		.o_y  (alu_y)
	);

	// ====================
	// condition check
	// ====================
	always_comb
	begin
		case (stage.cond)
			cond_z:  cond_ok = z_flag;
			cond_nz: cond_ok = !z_flag; // zero flag, not n
			cond_n:  cond_ok = n_flag;
			default: cond_ok = 1'b1;    // al
		endcase
	end

	assign commit = stage.valid && cond_ok;

	// ====================
	// write back, branch
	// ====================
	// reg file write lands on the edge that ends this cycle
	assign o_wr_en   = commit && stage.wr_reg;
	assign o_wr_adr  = stage.dest;
	assign o_wr_data = alu_y;

	// same value bypassed to the instruction now in decode
	assign stage.fwd_en   = o_wr_en;
	assign stage.fwd_dest = stage.dest;
	assign stage.fwd_data = alu_y;

	assign o_branch    = commit && stage.do_branch; // taken bf
	assign o_offset    = stage.offset;
	assign stage.flush = o_branch;                  // squash the two shadow slots

	// flags and output strobe
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			z_flag      <= 1'b0;
			n_flag      <= 1'b0;
			o_out_valid <= 1'b0;
		end
		else
		begin
			o_out_valid <= commit && stage.do_out; // one cycle pulse
			if (commit && stage.do_test)
			begin
				z_flag <= (stage.operand_a == '0);
				n_flag <= stage.operand_a[d_width-1];
			end
		end
	end

	// output port data, held between writes
	always_ff @(posedge clk)
	begin
		if (commit && stage.do_out)
		begin
			o_out_value <= stage.operand_a;
		end
	end

endmodule

// File: pat_pc.sv
`timescale 1ns/100ps

module pat_pc (
	input  logic           clk,
	input  logic           reset,
	input  logic           i_branch,
	input  pat_pkg::data_t i_offset,
	output pat_pkg::pc_t   o_pc,
	output logic           o_jump
);
	import pat_pkg::*;

	pc_t pc_q;
	pc_t issued [2]; // [0] shown last cycle, [1] two cycles back
	pc_t offset_ext;
	pc_t target;

	// the instruction in execute was fetched two cycles ago
	assign offset_ext = {{(i_adr_width-d_width){i_offset[d_width-1]}}, i_offset};
	assign target     = issued[1] + offset_ext;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc_q   <= '0;
			o_jump <= 1'b0;
		end
		else
		begin
			o_jump <= i_branch; // high the cycle the target shows
			if (i_branch)
				pc_q <= target;
			else
				pc_q <= pc_q + 1'b1;
		end
	end

	// address history
	always_ff @(posedge clk)
	begin
		issued[0] <= pc_q;
		issued[1] <= issued[0];
	end

	assign o_pc = pc_q;

endmodule

// File: pat_pkg.sv
package pat_pkg;

	// ====================
	// widths
	// ====================
	localparam int d_width     = 8;  // data word
	localparam int d_adr_width = 3;  // register index
	localparam int i_width     = 23; // instruction word
	localparam int i_adr_width = 10; // program counter
	localparam int n_inputs    = 3;  // input ports
	localparam int op_width    = 4;  // every opcode field
	localparam int cond_width  = 2;

	// ====================
	// instruction fields
	// ====================
	// bits 19..12 once held field pointers and field_op, now zero
	// except for the cond pair sitting inside that range
	localparam int rn_lsb   = 20; // Rn, 22..20
	localparam int cond_lsb = 13; // cond, 14..13
	localparam int op8_lsb  = 8;  // opcode_i8, 11..8
	localparam int op3_lsb  = 4;  // i3 opcode overlays imm8[7:4]
	localparam int op0_lsb  = 0;  // i0 opcode overlays imm8[3:0]
	localparam int imm_lsb  = 0;  // imm8, 7..0

	// escape code, i8 -> i3 and i3 -> i0
	localparam logic [op_width-1:0] prefix_code = 4'b1111;

	// i8 space
	localparam logic [op_width-1:0] op8_ori  = 4'b0000;
	localparam logic [op_width-1:0] op8_orr  = 4'b0001;
	localparam logic [op_width-1:0] op8_andi = 4'b0010;
	localparam logic [op_width-1:0] op8_andr = 4'b0011;
	localparam logic [op_width-1:0] op8_addi = 4'b0100;
	localparam logic [op_width-1:0] op8_addr = 4'b0101;
	localparam logic [op_width-1:0] op8_subi = 4'b0110;
	localparam logic [op_width-1:0] op8_subr = 4'b0111;
	localparam logic [op_width-1:0] op8_ldi  = 4'b1000;
	localparam logic [op_width-1:0] op8_bf   = 4'b1101; // signed offset in imm8

	// i3 space, amount or port code in imm[2:0]
	localparam logic [op_width-1:0] op3_shlz = 4'b0000;
	localparam logic [op_width-1:0] op3_shlo = 4'b0010;
	localparam logic [op_width-1:0] op3_shrz = 4'b0100;
	localparam logic [op_width-1:0] op3_asr  = 4'b0110;
	localparam logic [op_width-1:0] op3_in   = 4'b1010; // own code, no longer aliases shrz
	localparam logic [op_width-1:0] op3_out  = 4'b1011;

	// i0 space
	localparam logic [op_width-1:0] op0_not  = 4'b0000;
	localparam logic [op_width-1:0] op0_test = 4'b0010;
	localparam logic [op_width-1:0] op0_nop  = 4'b1111;

	// condition codes
	localparam logic [cond_width-1:0] cond_z  = 2'd0;
	localparam logic [cond_width-1:0] cond_nz = 2'd1;
	localparam logic [cond_width-1:0] cond_n  = 2'd2;
	localparam logic [cond_width-1:0] cond_al = 2'd3;

	// ====================
	// types
	// ====================
	typedef logic [d_width-1:0]     data_t;
	typedef logic [d_adr_width-1:0] reg_adr_t;
	typedef logic [i_adr_width-1:0] pc_t;

	typedef enum logic [3:0] {
		alu_or,
		alu_and,
		alu_add,
		alu_sub,
		alu_pass_b, // ldi, in
		alu_not_a,
		alu_shlz,
		alu_shlo,
		alu_shrz,
		alu_asr
	} alu_op_e;

	// Rn 0, field bits 0, cond AL, then prefix, prefix, nop
	localparam logic [i_width-1:0] nop_instr =
		{3'd0, 5'd0, cond_al, 1'b0, prefix_code, prefix_code, op0_nop};

endpackage

// File: pat_reg_file.sv
`timescale 1ns/100ps

module pat_reg_file (
	input  logic              clk,
	input  pat_pkg::reg_adr_t i_rd_adr_a,
	input  pat_pkg::reg_adr_t i_rd_adr_b,
	output pat_pkg::data_t    o_rd_data_a,
	output pat_pkg::data_t    o_rd_data_b,
	input  logic              i_wr_en,
	input  pat_pkg::reg_adr_t i_wr_adr,
	input  pat_pkg::data_t    i_wr_data
);
	import pat_pkg::*;

	data_t regs [2**d_adr_width]; // r0..r7

	// asynchronous reads, old value on a same-cycle write
	// (the decoder bypass covers that case)
	assign o_rd_data_a = regs[i_rd_adr_a];
	assign o_rd_data_b = regs[i_rd_adr_b];

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
		begin
			regs[i_wr_adr] <= i_wr_data;
		end
	end

endmodule

// File: pat_stage_if.sv
`timescale 1ns/100ps

// decode -> execute pipeline register contents plus the feedback
// from execute (branch flush and the write-back forwarding path)
interface pat_stage_if;
	import pat_pkg::*;

	// forward direction, registered in the decoder
	logic                  valid;     // one cycle per instruction
	alu_op_e               alu_op;
	data_t                 operand_a; // Rn
	data_t                 operand_b; // reg, imm, or input port
	reg_adr_t              dest;
	logic [cond_width-1:0] cond;
	logic                  wr_reg;
	logic                  do_out;
	logic                  do_test;
	logic                  do_branch;
	data_t                 offset;    // bf displacement

	// backward direction, combinational in execute
	logic                  flush;     // taken branch this cycle
	logic                  fwd_en;
	reg_adr_t              fwd_dest;
	data_t                 fwd_data;

	modport decode (
		output valid, alu_op, operand_a, operand_b, dest, cond,
		output wr_reg, do_out, do_test, do_branch, offset,
		input  flush, fwd_en, fwd_dest, fwd_data
	);

	modport execute (
		input  valid, alu_op, operand_a, operand_b, dest, cond,
		input  wr_reg, do_out, do_test, do_branch, offset,
		output flush, fwd_en, fwd_dest, fwd_data
	);

endinterface

// File: pat_top.sv
`timescale 1ns/100ps

module pat_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [pat_pkg::i_width-1:0] i_instruction, // word at o_pc, one cycle late
	input  pat_pkg::data_t              i_in_0,
	input  pat_pkg::data_t              i_in_1,
	input  pat_pkg::data_t              i_in_2,
	output pat_pkg::pc_t                o_pc,
	output logic                        o_jump,
	output pat_pkg::data_t              o_out_value,
	output logic                        o_out_valid
);
	import pat_pkg::*;

	reg_adr_t rd_adr_a, rd_adr_b;
	data_t    rd_data_a, rd_data_b;
	logic     wr_en;
	reg_adr_t wr_adr;
	data_t    wr_data;
	logic     branch;
	data_t    offset;

	pat_stage_if stage_bus ();

	// ====================
	// stage 1, decode
	// ====================
	pat_decoder u_decoder (
		.clk           (clk),
		.reset         (reset),
		.i_instruction (i_instruction),
		.i_in_0        (i_in_0),
		.i_in_1        (i_in_1),
		.i_in_2        (i_in_2),
		.o_rd_adr_a    (rd_adr_a),
		.o_rd_adr_b    (rd_adr_b),
		.i_rd_data_a   (rd_data_a),
		.i_rd_data_b   (rd_data_b),
		.stage         (stage_bus.decode)
	);

	pat_reg_file u_reg_file (
		.clk         (clk),
		.i_rd_adr_a  (rd_adr_a),
		.i_rd_adr_b  (rd_adr_b),
		.o_rd_data_a (rd_data_a),
		.o_rd_data_b (rd_data_b),
		.i_wr_en     (wr_en),
		.i_wr_adr    (wr_adr),
		.i_wr_data   (wr_data)
	);

	// ====================
	// stage 2, execute
	// ====================
	pat_execute u_execute (
		.clk         (clk),
		.reset       (reset),
		.stage       (stage_bus.execute),
		.o_wr_en     (wr_en),
		.o_wr_adr    (wr_adr),
		.o_wr_data   (wr_data),
		.o_branch    (branch),
		.o_offset    (offset),
		.o_out_value (o_out_value),
		.o_out_valid (o_out_valid)
	);

	pat_pc u_pc (
		.clk      (clk),
		.reset    (reset),
		.i_branch (branch),
		.i_offset (offset),
		.o_pc     (o_pc),
		.o_jump   (o_jump)
	);

endmodule

// File: sources.f
+incdir+.
pat_pkg.sv
pat_stage_if.sv
pat_reg_file.sv
pat_alu.sv
pat_decoder.sv
pat_execute.sv
pat_pc.sv
pat_top.sv
tb_pat.sv

// File: tb_pat_util.svh
// ====================
// random numbers
// ====================
// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic lfsr_step();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	int          i;
	v = '0;
	for (i = 0; i < n; i++)
		v = {v[30:0], lfsr_step()};
	return v;
endfunction

function automatic data_t rand_byte();
	return data_t'(rand_bits(8));
endfunction

function automatic logic [2:0] rand3();
	return 3'(rand_bits(3));
endfunction

// ====================
// instruction words
// ====================
// Rn 22..20, zero 19..15, cond 14..13, zero 12, op8 11..8, imm 7..0
function automatic logic [i_width-1:0] i8_word(input logic [1:0] cond, input logic [3:0] op,
	input reg_adr_t rn, input data_t imm);
	return {rn, 5'd0, cond, 1'b0, op, imm};
endfunction

// i3 opcode in imm[7:4], argument in imm[2:0]
function automatic logic [i_width-1:0] i3_word(input logic [1:0] cond, input logic [3:0] op,
	input reg_adr_t rn, input logic [2:0] arg);
	return i8_word(cond, prefix_code, rn, {op, 1'b0, arg});
endfunction

function automatic logic [i_width-1:0] i0_word(input logic [1:0] cond, input logic [3:0] op,
	input reg_adr_t rn);
	return i8_word(cond, prefix_code, rn, {prefix_code, op}); // two escapes
endfunction

task automatic emit(input logic [i_width-1:0] w);
	imem[prog_len] = w;
	prog_len++;
endtask

// ====================
// waits and counting
// ====================
task automatic wait_for_pc(input int target, input int limit);
	int n;
	n = 0;
	while (o_pc != pc_t'(target) && n < limit)
	begin
		@(negedge clk); // outputs settled
		n++;
	end
	if (o_pc != pc_t'(target))
	begin
		$display("timeout: o_pc never reached %0d within %0d cycles", target, limit);
		test_errors++;
	end
endtask

task automatic note_error(input string msg);
	$display("FAILED at %0t: %s", $time, msg);
	test_errors++;
endtask

task automatic check_counts();
	assert (out_idx == exp_n)
	else note_error($sformatf("%0d output strobes, expected %0d", out_idx, exp_n));
	assert (jump_idx == exp_jumps)
	else note_error($sformatf("%0d jumps, expected %0d", jump_idx, exp_jumps));
endtask

task automatic finish_test(input string name);
	tests_run++;
	if (test_errors == 0)
		$display("test %0d, %s: passed", tests_run, name);
	else
	begin
		$display("test %0d, %s: failed with %0d errors", tests_run, name, test_errors);
		tests_failed++;
	end
	error_total += test_errors;
	test_errors = 0;
endtask

// File: tb_pat.sv
`timescale 1ns/100ps

module tb_pat;
	import pat_pkg::*;

	logic               clk;
	logic               reset;
	logic [i_width-1:0] i_instruction;
	data_t              i_in_0, i_in_1, i_in_2;
	pc_t                o_pc;
	logic               o_jump;
	data_t              o_out_value;
	logic               o_out_valid;

	logic [i_width-1:0] imem [1024]; // instruction memory model
	int                 prog_len;
	data_t              in_val [n_inputs];
	logic [31:0]        lfsr_state = 32'h50e1_66e1;

	// expectations from the isa model
	data_t              exp_out [64];
	int                 exp_n;
	pc_t                exp_target [16];
	int                 exp_jumps;
	int                 out_idx, jump_idx; // responses seen so far
	pc_t                pc_prev;
	logic               pc_prev_ok;
	int                 test_errors, tests_run, tests_failed, error_total;

	`include "tb_pat_util.svh"

	pat_top uut (
		.clk           (clk),
		.reset         (reset),
		.i_instruction (i_instruction),
		.i_in_0        (i_in_0),
		.i_in_1        (i_in_1),
		.i_in_2        (i_in_2),
		.o_pc          (o_pc),
		.o_jump        (o_jump),
		.o_out_value   (o_out_value),
		.o_out_valid   (o_out_valid)
	);

	always #50 clk = ~clk; // 100 ns period

	// fetch model where the word shows one cycle after its address
	always @(posedge clk)
		i_instruction <= imem[o_pc];

	// response bookkeeping
	always @(posedge clk)
	begin
		if (reset)
		begin
			out_idx    <= 0;
			jump_idx   <= 0;
			pc_prev_ok <= 1'b0;
		end
		else
		begin
			if (o_out_valid)
				out_idx <= out_idx + 1;
			if (o_jump)
				jump_idx <= jump_idx + 1;
			pc_prev    <= o_pc;
			pc_prev_ok <= 1'b1;
		end
	end

	// ====================
	// assertions
	// ====================
	out_check: assert property (@(posedge clk) disable iff (reset)
		o_out_valid |-> (out_idx < exp_n) && (o_out_value == exp_out[out_idx]))
	else
		note_error($sformatf("out strobe %0d value %h, expected %h of %0d strobes",
			$sampled(out_idx), $sampled(o_out_value), exp_out[$sampled(out_idx)], exp_n));

	jump_check: assert property (@(posedge clk) disable iff (reset)
		o_jump |-> (jump_idx < exp_jumps) && (o_pc == exp_target[jump_idx]))
	else
		note_error($sformatf("jump %0d to o_pc %0d, expected %0d", $sampled(jump_idx),
			$sampled(o_pc), exp_target[$sampled(jump_idx)]));

	count_check: assert property (@(posedge clk) disable iff (reset)
		pc_prev_ok && !o_jump |-> o_pc == pc_t'(pc_prev + 1'b1))
	else
		note_error($sformatf("o_pc %0d after %0d, no jump", $sampled(o_pc), $sampled(pc_prev)));

	// ====================
	// isa model
	// ====================
	task automatic run_model();
		pc_t      pc, next;
		data_t    r [8];
		logic     zf, nf, ok;
		reg_adr_t rn;
		data_t    a, im;
		int       k, steps;
		pc    = '0;
		r     = '{default: '0};
		zf    = 1'b0; // flags clear out of reset
		nf    = 1'b0;
		steps = 0;
		exp_n     = 0;
		exp_jumps = 0;
		while (int'(pc) < prog_len && steps < 1000)
		begin
			rn   = imem[pc][rn_lsb +: 3];
			im   = imem[pc][imm_lsb +: 8];
			a    = r[rn];
			k    = im[1:0] + 1;  // shift distance 1..4
			next = pc + 1'b1;
			case (imem[pc][cond_lsb +: 2])
				cond_z:  ok = zf;
				cond_nz: ok = !zf;
				cond_n:  ok = nf;
				default: ok = 1'b1;
			endcase
			if (ok && imem[pc][op8_lsb +: 4] != prefix_code)
			begin
				case (imem[pc][op8_lsb +: 4])
					op8_ori:  r[rn] = a | im;
					op8_orr:  r[rn] = a | r[im[2:0]];
					op8_andi: r[rn] = a & im;
					op8_andr: r[rn] = a & r[im[2:0]];
					op8_addi: r[rn] = a + im;
					op8_addr: r[rn] = a + r[im[2:0]];
					op8_subi: r[rn] = a - im;
					op8_subr: r[rn] = a - r[im[2:0]];
					op8_ldi:  r[rn] = im;
					op8_bf:
					begin
						next = pc + {{(i_adr_width-d_width){im[7]}}, im};
						exp_target[exp_jumps] = next;
						exp_jumps++;
					end
					default: ;
				endcase
			end
			else if (ok && im[7:4] != prefix_code)
			begin
				case (im[7:4])
					op3_shlz: r[rn] = a << k;
					op3_shlo: r[rn] = ~(~a << k);              // ones shifted in
					op3_shrz: r[rn] = a >> k;
					op3_asr:  r[rn] = data_t'($signed(a) >>> k);
					op3_in:   r[rn] = (im[2:0] == 3'b010) ? in_val[1] :
						(im[2:0] == 3'b100) ? in_val[2] : in_val[0];
					op3_out:
					begin
						exp_out[exp_n] = a;
						exp_n++;
					end
					default: ;
				endcase
			end
			else if (ok)
			begin
				case (im[3:0])
					op0_not: r[rn] = ~a;
					op0_test:
					begin
						zf = (a == '0);
						nf = a[7];
					end
					default: ;
				endcase
			end
			pc = next;
			steps++;
		end
	endtask

	task automatic hold_reset();
		int i;
		@(posedge clk);
		reset <= 1'b1;
		for (i = 0; i < n_inputs; i++)
			in_val[i] = rand_byte();
		i_in_0 <= in_val[0];
		i_in_1 <= in_val[1];
		i_in_2 <= in_val[2];
		@(negedge clk);
		for (i = 0; i < 1024; i++)
			imem[i] = nop_instr;
		prog_len = 0;
	endtask

	task automatic release_reset();
		repeat (3) @(posedge clk); // reset high for 3 cycles
		reset <= 1'b0;
		@(negedge clk);
	endtask

	task automatic run_program(input string name);
		run_model();
		release_reset();
		wait_for_pc(prog_len + 4, 400); // past the last commit
		check_counts();
		finish_test(name);
	endtask

	// ====================
	// tests
	// ====================
	initial
	begin
		int              i;
		logic [3:0]      ops8 [8];
		logic [3:0]      ops3 [4];
		logic [2:0]      codes [5];
		data_t           tvals [3];
		logic [2:0]      sel;
		reg_adr_t        rn;
		clk           = 1'b0;
		reset         = 1'b1;
		i_instruction = nop_instr;
		i_in_0        = '0;
		i_in_1        = '0;
		i_in_2        = '0;
		test_errors   = 0;
		tests_run     = 0;
		tests_failed  = 0;
		error_total   = 0;
		ops8  = '{op8_ori, op8_orr, op8_andi, op8_andr, op8_addi, op8_addr, op8_subi, op8_subr};
		ops3  = '{op3_shlz, op3_shlo, op3_shrz, op3_asr};
		codes = '{3'b001, 3'b010, 3'b100, 3'b000, 3'b110}; // last two invalid

		// reset state then free counting over nops
		hold_reset();
		for (i = 0; i < 16; i++)
			emit(nop_instr);
		run_model();
		release_reset();
		assert (o_pc == '0 && !o_jump && !o_out_valid)
		else note_error($sformatf("after reset o_pc %0d jump %b out_valid %b",
			o_pc, o_jump, o_out_valid));
		wait_for_pc(prog_len + 4, 100);
		check_counts();
		finish_test("reset and pc count");

		// i8 ops with each result straight into out
		hold_reset();
		for (i = 0; i < 8; i++)
			emit(i8_word(cond_al, op8_ldi, reg_adr_t'(i), rand_byte()));
		for (i = 0; i < 16; i++)
		begin
			sel = rand3();
			rn  = rand3();
			emit(i8_word(cond_al, ops8[sel], rn, sel[0] ? {5'd0, rand3()} : rand_byte()));
			emit(i3_word(cond_al, op3_out, rn, 3'd0));
		end
		emit(i8_word(cond_al, op8_ldi, 3'd0, rand_byte()));
		emit(i8_word(cond_al, op8_addr, 3'd1, 8'd0)); // r0 as operand b right after its ldi
		emit(i3_word(cond_al, op3_out, 3'd1, 3'd0));
		run_program("i8 operations");

		// shifts 1..4 and not
		hold_reset();
		for (i = 0; i < 20; i++)
		begin
			emit(i8_word(cond_al, op8_ldi, 3'd1, rand_byte()));
			if (i % 5 == 4)
				emit(i0_word(cond_al, op0_not, 3'd1));
			else
				emit(i3_word(cond_al, ops3[i % 5], 3'd1, {1'b0, 2'(i / 5)})); // one amount per pass
			emit(i3_word(cond_al, op3_out, 3'd1, 3'd0));
		end
		run_program("shifts and not");

		// in ports by one-hot code
		hold_reset();
		for (i = 0; i < 5; i++)
		begin
			emit(i3_word(cond_al, op3_in, 3'd2, codes[i]));
			emit(i3_word(cond_al, op3_out, 3'd2, 3'd0));
		end
		run_program("input ports");

		// flags from test then conditional out
		hold_reset();
		tvals = '{8'h00, rand_byte() | 8'h80, (rand_byte() & 8'h7f) | 8'h01};
		for (i = 4; i < 8; i++)
			emit(i8_word(cond_al, op8_ldi, reg_adr_t'(i), data_t'(i * 8'h11)));
		emit(i3_word(cond_z, op3_out, 3'd4, 3'd0)); // z clear out of reset
		emit(i3_word(cond_n, op3_out, 3'd6, 3'd0)); // n clear as well
		for (i = 0; i < 3; i++)
		begin
			emit(i8_word(cond_al, op8_ldi, 3'd3, tvals[i]));
			emit(i0_word(cond_al, op0_test, 3'd3));
			emit(i3_word(cond_z, op3_out, 3'd4, 3'd0));
			emit(i3_word(cond_nz, op3_out, 3'd5, 3'd0));
			emit(i3_word(cond_n, op3_out, 3'd6, 3'd0));
			emit(i3_word(cond_al, op3_out, 3'd7, 3'd0));
		end
		run_program("flags and conditions");

		// forward and not taken branches then a backward loop
		hold_reset();
		emit(i8_word(cond_al, op8_ldi, 3'd5, 8'h55));
		emit(i8_word(cond_al, op8_ldi, 3'd6, 8'h66));
		emit(i8_word(cond_al, op8_ldi, 3'd7, 8'h77));
		emit(i8_word(cond_al, op8_bf, 3'd0, 8'd4));  // 3 -> 7
		emit(i3_word(cond_al, op3_out, 3'd6, 3'd0)); // shadow
		emit(i3_word(cond_al, op3_out, 3'd6, 3'd0)); // shadow
		emit(i3_word(cond_al, op3_out, 3'd6, 3'd0)); // jumped over
		emit(i3_word(cond_al, op3_out, 3'd5, 3'd0));
		emit(i0_word(cond_al, op0_test, 3'd5));      // z = 0
		emit(i8_word(cond_z, op8_bf, 3'd0, 8'd8));   // fails
		emit(i3_word(cond_al, op3_out, 3'd6, 3'd0));
		emit(i3_word(cond_al, op3_out, 3'd6, 3'd0));
		emit(i8_word(cond_al, op8_ldi, 3'd0, 8'd3));
		emit(i8_word(cond_al, op8_subi, 3'd0, 8'd1)); // loop top at 13
		emit(i0_word(cond_al, op0_test, 3'd0));
		emit(i3_word(cond_al, op3_out, 3'd0, 3'd0));
		emit(i8_word(cond_nz, op8_bf, 3'd0, 8'hfd));  // 16 -> 13
		emit(i3_word(cond_al, op3_out, 3'd7, 3'd0));  // shadows that run once on exit
		emit(i3_word(cond_al, op3_out, 3'd7, 3'd0));
		emit(nop_instr);
		run_program("branches");

		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, error_total);
		if (tests_failed == 0 && error_total == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
